/* source/image_pkg.sv */
package image_pkg;

	localparam int PIXEL_BITS = 8;
	localparam int COORD_BITS = 12;

	// Covers a resized frame up to 256 x 256 samples of 8 bits.
	localparam int INTEGRAL_BITS = 24;

	localparam int LBP_BITS = 8;
	localparam int LBP_GRID = 4; // Corners per axis of a 3x3 block layout.

	// Luminance only.
	typedef logic [PIXEL_BITS-1:0] pixel_t;

	// Shared by original and resized positions.
	typedef logic [COORD_BITS-1:0] coord_t;

	typedef logic [INTEGRAL_BITS-1:0] integral_t;

	// Bit 7 is the top-left neighbour block, then clockwise down to
	// bit 0 at the left-middle block. A bit is set when the neighbour
	// sum is greater than or equal to the centre sum.
	typedef logic [LBP_BITS-1:0] lbp_code_t;

endpackage

/* source/cascade_pkg.sv */
package cascade_pkg;

	typedef enum logic [1:0]
	{
		TAG_FEATURE = 2'd0,
		TAG_LEAF = 2'd1,
		TAG_STAGE_END = 2'd2,
		TAG_CASCADE_END = 2'd3
	} db_tag_t;

	typedef logic signed [11:0] db_value_t;

	// Stage accumulator, wide enough for many leaves.
	typedef logic signed [15:0] score_t;

	typedef struct packed
	{
		db_tag_t tag;
		logic [3:0] x; // Block grid origin.
		logic [3:0] y;
		logic [2:0] w_m1; // Block width minus one.
		logic [2:0] h_m1;
		logic [7:0] pad;
	} db_feature_t;

	// Leaf: code and weight. Stage end: value is the threshold.
	typedef struct packed
	{
		db_tag_t tag;
		logic [1:0] pad;
		logic [7:0] code;
		db_value_t value;
	} db_score_t;

	// The tag sits in the same bits in both views.
	typedef union packed
	{
		db_feature_t feature;
		db_score_t score;
	} db_word_t;

endpackage

/* source/coordinate_resizer.sv */
`timescale 1ns/1ps

module coordinate_resizer import image_pkg::*;
#(
	parameter int ORIGINAL_WIDTH = 20,
	parameter int ORIGINAL_HEIGHT = 20,
	parameter int RESIZE_WIDTH = 10,
	parameter int RESIZE_HEIGHT = 10
)
(
	input logic clk,
	input logic reset,
	input logic i_valid,
	input pixel_t i_pixel,
	input coord_t i_ori_x,
	input coord_t i_ori_y,
	output logic o_sample_valid,
	output pixel_t o_pixel,
	output coord_t o_resize_x,
	output coord_t o_resize_y
);

	coord_t map_x;
	coord_t map_y;
	logic new_col;
	logic new_row;

	// Nearest neighbour, rounded down.
	function automatic coord_t scale(input coord_t c, input int resize_dim, input int original_dim);
		return coord_t'((int'(c) * resize_dim) / original_dim);
	endfunction

	always_comb
	begin
		map_x = scale(i_ori_x, RESIZE_WIDTH, ORIGINAL_WIDTH);
		map_y = scale(i_ori_y, RESIZE_HEIGHT, ORIGINAL_HEIGHT);
		new_col = (i_ori_x == '0) ||
			(scale(i_ori_x - coord_t'(1), RESIZE_WIDTH, ORIGINAL_WIDTH) != map_x);
		new_row = (i_ori_y == '0) ||
			(scale(i_ori_y - coord_t'(1), RESIZE_HEIGHT, ORIGINAL_HEIGHT) != map_y);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_sample_valid <= 1'b0;
			o_resize_x <= '0;
			o_resize_y <= '0;
		end
		else
		begin
			o_sample_valid <= i_valid && new_col && new_row; // First hit of a resized cell.
			if (i_valid)
			begin
				o_resize_x <= map_x;
				o_resize_y <= map_y;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (i_valid)
		begin
			o_pixel <= i_pixel;
		end
	end

endmodule

/* source/integral_frame_memory.sv */
`timescale 1ns/1ps

module integral_frame_memory import image_pkg::*;
#(
	parameter int RESIZE_WIDTH = 10,
	parameter int RESIZE_HEIGHT = 10
)
(
	input logic clk,
	input logic reset,
	input logic i_write,
	input pixel_t i_pixel,
	input coord_t i_x,
	input coord_t i_y,
	input coord_t i_rd_x,
	input coord_t i_rd_y,
	output integral_t o_rd_value,
	output logic o_frame_ready
);

	localparam int DEPTH = RESIZE_WIDTH * RESIZE_HEIGHT;
	localparam int ADDR_BITS = $clog2(DEPTH);
	localparam coord_t LAST_X = coord_t'(RESIZE_WIDTH - 1);
	localparam coord_t LAST_Y = coord_t'(RESIZE_HEIGHT - 1);
	localparam coord_t PAD_W = coord_t'(RESIZE_WIDTH);
	localparam coord_t PAD_H = coord_t'(RESIZE_HEIGHT);

	// Only the non-zero part of the padded image is stored.
	integral_t integral_mem [DEPTH];
	integral_t row_sum;
	integral_t row_next;
	integral_t above;
	logic [ADDR_BITS-1:0] wr_addr;
	logic [ADDR_BITS-1:0] up_addr;
	logic [ADDR_BITS-1:0] rd_addr;
	coord_t rd_x_clamped;
	coord_t rd_y_clamped;

	always_comb
	begin
		wr_addr = ADDR_BITS'(int'(i_y) * RESIZE_WIDTH + int'(i_x));
		up_addr = ADDR_BITS'((int'(i_y) - 1) * RESIZE_WIDTH + int'(i_x));
		row_next = ((i_x == '0) ? '0 : row_sum) + integral_t'(i_pixel); // New row restarts.
		above = (i_y == '0) ? '0 : integral_mem[up_addr];
	end

	// Beyond the frame the padded image is zero, so edge values repeat.
	always_comb
	begin
		rd_x_clamped = (i_rd_x > PAD_W) ? PAD_W : i_rd_x;
		rd_y_clamped = (i_rd_y > PAD_H) ? PAD_H : i_rd_y;
		rd_addr = ADDR_BITS'((int'(rd_y_clamped) - 1) * RESIZE_WIDTH + int'(rd_x_clamped) - 1);
		if (rd_x_clamped == '0 || rd_y_clamped == '0)
		begin
			o_rd_value = '0; // Padding row and column.
		end
		else
		begin
			o_rd_value = integral_mem[rd_addr];
		end
	end

	always_ff @(posedge clk)
	begin
		if (i_write)
		begin
			row_sum <= row_next;
			integral_mem[wr_addr] <= row_next + above;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_frame_ready <= 1'b0;
		end
		else if (i_write)
		begin
			if (i_x == '0 && i_y == '0)
			begin
				o_frame_ready <= 1'b0; // A new frame overwrites.
			end
			else if (i_x == LAST_X && i_y == LAST_Y)
			begin
				o_frame_ready <= 1'b1;
			end
		end
	end

endmodule

/* source/lbp_cascade_evaluator.sv */
`timescale 1ns/1ps

module lbp_cascade_evaluator import image_pkg::*; import cascade_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic i_start,
	input logic i_db_valid,
	input db_word_t i_db_word,
	output logic o_db_request,
	output coord_t o_rd_x,
	output coord_t o_rd_y,
	input integral_t i_rd_value,
	output logic o_done,
	output logic o_candidate
);

	typedef enum logic [2:0] {IDLE, FETCH, CORNER, CODE, DONE} state_t;

	state_t state;
	logic [3:0] corner_idx;
	logic [3:0] feat_x;
	logic [3:0] feat_y;
	logic [3:0] block_w;
	logic [3:0] block_h;
	integral_t corner [LBP_GRID*LBP_GRID];
	integral_t block_sum [9];
	lbp_code_t lbp_code;
	lbp_code_t next_code;
	score_t stage_score;
	logic decision;

	assign o_db_request = (state == FETCH);
	assign o_done = (state == DONE);
	assign o_candidate = decision;

	// Corner index runs row by row over the 4x4 grid.
	always_comb
	begin
		o_rd_x = coord_t'(feat_x) + coord_t'(corner_idx[1:0]) * coord_t'(block_w);
		o_rd_y = coord_t'(feat_y) + coord_t'(corner_idx[3:2]) * coord_t'(block_h);
	end

	always_comb
	begin
		for (int by = 0; by < 3; by++)
		begin
			for (int bx = 0; bx < 3; bx++)
			begin
				block_sum[by*3+bx] = corner[(by+1)*LBP_GRID+bx+1] - corner[by*LBP_GRID+bx+1]
					- corner[(by+1)*LBP_GRID+bx] + corner[by*LBP_GRID+bx];
			end
		end
	end

	// Clockwise from the top-left block, centre is block 4.
	always_comb
	begin
		next_code[7] = block_sum[0] >= block_sum[4];
		next_code[6] = block_sum[1] >= block_sum[4];
		next_code[5] = block_sum[2] >= block_sum[4];
		next_code[4] = block_sum[5] >= block_sum[4];
		next_code[3] = block_sum[8] >= block_sum[4];
		next_code[2] = block_sum[7] >= block_sum[4];
		next_code[1] = block_sum[6] >= block_sum[4];
		next_code[0] = block_sum[3] >= block_sum[4];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= IDLE;
			corner_idx <= '0;
			stage_score <= '0;
			decision <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (i_start)
					begin
						stage_score <= '0;
						state <= FETCH;
					end
				end
				FETCH:
				begin
					if (i_db_valid)
					begin
						case (i_db_word.feature.tag)
							TAG_FEATURE:
							begin
								corner_idx <= '0;
								state <= CORNER;
							end
							TAG_LEAF:
							begin
								if (i_db_word.score.code == lbp_code)
								begin
									stage_score <= stage_score + score_t'(i_db_word.score.value);
								end
							end
							TAG_STAGE_END:
							begin
								if (stage_score < score_t'(i_db_word.score.value))
								begin
									decision <= 1'b0; // Rejected, skip the rest.
									state <= DONE;
								end
								else
								begin
									stage_score <= '0;
								end
							end
							default:
							begin
								decision <= 1'b1;
								state <= DONE;
							end
						endcase
					end
				end
				CORNER:
				begin
					corner_idx <= corner_idx + 4'd1;
					if (corner_idx == 4'd15)
					begin
						state <= CODE;
					end
				end
				CODE:
				begin
					state <= FETCH;
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == IDLE && i_start)
		begin
			lbp_code <= '0;
		end
		if (state == FETCH && i_db_valid && i_db_word.feature.tag == TAG_FEATURE)
		begin
			feat_x <= i_db_word.feature.x;
			feat_y <= i_db_word.feature.y;
			block_w <= {1'b0, i_db_word.feature.w_m1} + 4'd1;
			block_h <= {1'b0, i_db_word.feature.h_m1} + 4'd1;
		end
		if (state == CORNER)
		begin
			corner[corner_idx] <= i_rd_value;
		end
		if (state == CODE)
		begin
			lbp_code <= next_code;
		end
	end

endmodule

/* source/i2lbs_detector.sv */
`timescale 1ns/1ps

module i2lbs_detector import image_pkg::*; import cascade_pkg::*;
#(
	parameter int ORIGINAL_WIDTH = 20,
	parameter int ORIGINAL_HEIGHT = 20,
	parameter int RESIZE_WIDTH = 10,
	parameter int RESIZE_HEIGHT = 10
)
(
	input logic clk,
	input logic reset,
	input logic i_pixel_valid,
	input pixel_t i_pixel,
	input coord_t i_ori_x,
	input coord_t i_ori_y,
	input logic i_db_valid,
	input db_word_t i_db_word,
	output logic o_pixel_request,
	output logic o_database_request,
	output coord_t o_resize_x,
	output coord_t o_resize_y,
	output logic o_integral_image_ready,
	output logic o_inspect_done,
	output logic o_candidate
);

	typedef enum logic {COLLECT, INSPECT} state_t;

	state_t state;
	logic frame_fresh;
	logic collecting;
	logic pixel_accept;
	logic sample_valid;
	pixel_t sample_pixel;
	coord_t resize_x;
	coord_t resize_y;
	logic write_enable;
	logic frame_ready;
	logic eval_start;
	coord_t rd_x;
	coord_t rd_y;
	integral_t rd_value;
	logic eval_done;
	logic eval_candidate;

	// A finished frame left over from the last run does not restart the evaluator.
	assign eval_start = (state == COLLECT) && frame_ready && frame_fresh;
	assign collecting = (state == COLLECT) && !eval_start;
	assign pixel_accept = i_pixel_valid && collecting;
	assign write_enable = sample_valid && collecting;

	assign o_pixel_request = collecting;
	assign o_resize_x = resize_x;
	assign o_resize_y = resize_y;
	assign o_integral_image_ready = frame_ready;
	assign o_inspect_done = eval_done;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= COLLECT;
			frame_fresh <= 1'b0;
			o_candidate <= 1'b0;
		end
		else
		begin
			case (state)
				COLLECT:
				begin
					if (eval_start)
					begin
						frame_fresh <= 1'b0;
						state <= INSPECT;
					end
					else if (write_enable)
					begin
						frame_fresh <= 1'b1;
					end
				end
				default:
				begin
					if (eval_done)
					begin
						o_candidate <= eval_candidate; // Held until the next decision.
						state <= COLLECT;
					end
				end
			endcase
		end
	end

	coordinate_resizer
	#(
		.ORIGINAL_WIDTH(ORIGINAL_WIDTH),
		.ORIGINAL_HEIGHT(ORIGINAL_HEIGHT),
		.RESIZE_WIDTH(RESIZE_WIDTH),
		.RESIZE_HEIGHT(RESIZE_HEIGHT)
	)
	coordinate_resizer_i
	(
		.clk(clk),
		.reset(reset),
		.i_valid(pixel_accept),
		.i_pixel(i_pixel),
		.i_ori_x(i_ori_x),
		.i_ori_y(i_ori_y),
		.o_sample_valid(sample_valid),
		.o_pixel(sample_pixel),
		.o_resize_x(resize_x),
		.o_resize_y(resize_y)
	);

	integral_frame_memory
	#(
		.RESIZE_WIDTH(RESIZE_WIDTH),
		.RESIZE_HEIGHT(RESIZE_HEIGHT)
	)
	integral_frame_memory_i
	(
		.clk(clk),
		.reset(reset),
		.i_write(write_enable),
		.i_pixel(sample_pixel),
		.i_x(resize_x),
		.i_y(resize_y),
		.i_rd_x(rd_x),
		.i_rd_y(rd_y),
		.o_rd_value(rd_value),
		.o_frame_ready(frame_ready)
	);

	lbp_cascade_evaluator lbp_cascade_evaluator_i
	(
		.clk(clk),
		.reset(reset),
		.i_start(eval_start),
		.i_db_valid(i_db_valid),
		.i_db_word(i_db_word),
		.o_db_request(o_database_request),
		.o_rd_x(rd_x),
		.o_rd_y(rd_y),
		.i_rd_value(rd_value),
		.o_done(eval_done),
		.o_candidate(eval_candidate)
	);

endmodule

/* dv/i2lbs_properties.sv */
`timescale 1ns/1ps

module i2lbs_properties
(
	input logic clk,
	input logic reset,
	input logic i_pixel_request,
	input logic i_database_request,
	input logic i_integral_image_ready,
	input logic i_inspect_done,
	input logic i_candidate
);

	done_single_cycle: assert property (@(posedge clk) disable iff (reset)
		i_inspect_done |=> !i_inspect_done)
		else $error("inspect done stayed high for more than one cycle");

	requests_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(i_pixel_request && i_database_request))
		else $error("pixel request and database request were high together");

	// Only the pixel request may be high coming out of reset.
	reset_values: assert property (@(posedge clk)
		reset |=> (i_pixel_request && !i_database_request && !i_inspect_done
			&& !i_integral_image_ready && !i_candidate))
		else $error("control outputs have wrong values after reset");

endmodule

bind i2lbs_detector i2lbs_properties i2lbs_properties_i
(
	.clk(clk),
	.reset(reset),
	.i_pixel_request(o_pixel_request),
	.i_database_request(o_database_request),
	.i_integral_image_ready(o_integral_image_ready),
	.i_inspect_done(o_inspect_done),
	.i_candidate(o_candidate)
);

/* dv/i2lbs_checker.sv */
`timescale 1ns/1ps

module i2lbs_checker import image_pkg::*; import cascade_pkg::*;
#(
	parameter int ORIGINAL_WIDTH = 20,
	parameter int ORIGINAL_HEIGHT = 20,
	parameter int RESIZE_WIDTH = 10,
	parameter int RESIZE_HEIGHT = 10
)
(
	input logic clk,
	input logic reset,
	input logic i_pixel_valid,
	input pixel_t i_pixel,
	input coord_t i_ori_x,
	input coord_t i_ori_y,
	input logic i_db_valid,
	input db_word_t i_db_word,
	input logic i_pixel_request,
	input logic i_database_request,
	input coord_t i_resize_x,
	input coord_t i_resize_y,
	input logic i_image_ready,
	input logic i_inspect_done,
	input logic i_candidate,
	input int i_expected,
	output int o_tests,
	output int o_errors
);

	pixel_t frame [RESIZE_WIDTH*RESIZE_HEIGHT];
	db_word_t words [$];
	logic pend;
	logic done_seen;
	logic ready_prev;
	logic accepted;
	int exp_x;
	int exp_y;
	int samples;
	int model;

	function automatic int map(input int c, input int rdim, input int odim);
		return (c * rdim) / odim;
	endfunction

	// Blocks outside the resized frame count as zero.
	function automatic int block_sum(input int x0, input int y0, input int w, input int h);
		int sum;
		sum = 0;
		for (int r = y0; r < y0 + h; r++)
		begin
			for (int c = x0; c < x0 + w; c++)
			begin
				if (r < RESIZE_HEIGHT && c < RESIZE_WIDTH)
				begin
					sum += int'(frame[r*RESIZE_WIDTH+c]);
				end
			end
		end
		return sum;
	endfunction

	function automatic int lbp(input int x0, input int y0, input int w, input int h);
		int nx [8];
		int ny [8];
		int centre;
		int code;
		nx = '{0, 1, 2, 2, 2, 1, 0, 0}; // Clockwise from top-left, bit 7 first.
		ny = '{0, 0, 0, 1, 2, 2, 2, 1};
		centre = block_sum(x0 + w, y0 + h, w, h);
		code = 0;
		for (int i = 0; i < 8; i++)
		begin
			if (block_sum(x0 + nx[i]*w, y0 + ny[i]*h, w, h) >= centre)
			begin
				code |= 1 << (7 - i);
			end
		end
		return code;
	endfunction

	// Returns -1 when the words run out without a decision.
	function automatic int evaluate();
		int score;
		int code;
		db_word_t w;
		score = 0;
		code = 0;
		foreach (words[i])
		begin
			w = words[i];
			case (w.feature.tag)
				TAG_FEATURE:
					code = lbp(int'(w.feature.x), int'(w.feature.y),
						int'(w.feature.w_m1) + 1, int'(w.feature.h_m1) + 1);
				TAG_LEAF:
					if (int'(w.score.code) == code)
					begin
						score += int'(w.score.value);
					end
				TAG_STAGE_END:
					if (score < int'(w.score.value))
					begin
						return 0;
					end
					else
					begin
						score = 0;
					end
				default:
					return 1;
			endcase
		end
		return -1;
	endfunction

	always @(posedge clk)
	begin
		if (reset)
		begin
			pend = 1'b0;
			done_seen = 1'b0;
			ready_prev = 1'b0;
			samples = 0;
			o_tests = 0;
			o_errors = 0;
			words.delete();
		end
		else
		begin
			if (pend && (int'(i_resize_x) != exp_x || int'(i_resize_y) != exp_y))
			begin
				$display("MISMATCH o_resize_x/o_resize_y: got %h/%h expected %h/%h",
					i_resize_x, i_resize_y, exp_x, exp_y);
				o_errors++;
			end
			accepted = i_pixel_valid && i_pixel_request;
			pend = accepted;
			exp_x = map(int'(i_ori_x), RESIZE_WIDTH, ORIGINAL_WIDTH);
			exp_y = map(int'(i_ori_y), RESIZE_HEIGHT, ORIGINAL_HEIGHT);
			if (accepted
				&& (i_ori_x == 0 || map(int'(i_ori_x) - 1, RESIZE_WIDTH, ORIGINAL_WIDTH) != exp_x)
				&& (i_ori_y == 0 || map(int'(i_ori_y) - 1, RESIZE_HEIGHT, ORIGINAL_HEIGHT) != exp_y))
			begin
				if (exp_x == 0 && exp_y == 0)
				begin
					samples = 0;
				end
				frame[exp_y*RESIZE_WIDTH+exp_x] = i_pixel;
				samples++;
			end
			if (!ready_prev && i_image_ready)
			begin
				if (i_pixel_request)
				begin
					$display("Pixel request still high when the integral image became ready");
					o_errors++;
				end
				if (samples != RESIZE_WIDTH*RESIZE_HEIGHT)
				begin
					$display("Integral image ready after only %0d samples", samples);
					o_errors++;
				end
			end
			ready_prev = i_image_ready;
			if (i_database_request && i_db_valid)
			begin
				words.push_back(i_db_word);
			end
			if (done_seen)
			begin
				if (model < 0)
				begin
					$display("Evaluator finished before the cascade reached a decision");
					o_errors++;
				end
				else if (int'(i_candidate) != model)
				begin
					$display("MISMATCH o_candidate: got %h expected %h", i_candidate, model);
					o_errors++;
				end
				if (i_expected >= 0 && int'(i_candidate) != i_expected)
				begin
					$display("MISMATCH o_candidate: got %h table %h", i_candidate, i_expected);
					o_errors++;
				end
				$display("test %0d: candidate %h model %0d words %0d errors so far %0d",
					o_tests, i_candidate, model, words.size(), o_errors);
				o_tests++;
				words.delete();
				done_seen = 1'b0;
			end
			if (i_inspect_done)
			begin
				model = evaluate();
				done_seen = 1'b1;
			end
		end
	end

endmodule

/* dv/i2lbs_tb.sv */
`timescale 1ns/1ps

module i2lbs_tb import image_pkg::*; import cascade_pkg::*;
();

	localparam int OW = 20;
	localparam int OH = 20;
	localparam int RW = 10;
	localparam int RH = 10;
	localparam int NUM_TESTS = 6;
	localparam int MAX_FEATURES = 4;
	localparam int ROM_SIZE = 25;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * (OW*OH + 40 + 16*MAX_FEATURES) * 2;

	logic clk;
	logic reset;
	logic i_pixel_valid;
	pixel_t i_pixel;
	coord_t i_ori_x;
	coord_t i_ori_y;
	logic i_db_valid;
	db_word_t i_db_word;
	logic o_pixel_request;
	logic o_database_request;
	coord_t o_resize_x;
	coord_t o_resize_y;
	logic o_integral_image_ready;
	logic o_inspect_done;
	logic o_candidate;

	// Pattern 0 flat, 1 gradient, 2 random. Expected -1 means the model decides.
	int test_pattern [NUM_TESTS] = '{0, 0, 1, 2, 2, 1};
	int test_cascade [NUM_TESTS] = '{0, 1, 2, 2, 3, 2};
	int test_expected [NUM_TESTS] = '{0, 1, -1, -1, -1, -1};
	int test_gaps [NUM_TESTS] = '{0, 0, 0, 0, 0, 1};

	db_word_t rom [ROM_SIZE];
	int cascade_start [4] = '{0, 2, 4, 15};
	int seed;
	int db_ptr;
	int gap_count;
	logic gaps_active;
	int expected_candidate;
	int tests_done;
	int check_errors;

	i2lbs_detector #(.ORIGINAL_WIDTH(OW), .ORIGINAL_HEIGHT(OH),
		.RESIZE_WIDTH(RW), .RESIZE_HEIGHT(RH)) i2lbs_detector_i (.*);

	i2lbs_checker #(.ORIGINAL_WIDTH(OW), .ORIGINAL_HEIGHT(OH),
		.RESIZE_WIDTH(RW), .RESIZE_HEIGHT(RH)) i2lbs_checker_i
	(
		.clk(clk), .reset(reset), .i_pixel_valid(i_pixel_valid), .i_pixel(i_pixel),
		.i_ori_x(i_ori_x), .i_ori_y(i_ori_y), .i_db_valid(i_db_valid), .i_db_word(i_db_word),
		.i_pixel_request(o_pixel_request), .i_database_request(o_database_request),
		.i_resize_x(o_resize_x), .i_resize_y(o_resize_y),
		.i_image_ready(o_integral_image_ready), .i_inspect_done(o_inspect_done),
		.i_candidate(o_candidate), .i_expected(expected_candidate),
		.o_tests(tests_done), .o_errors(check_errors)
	);

	function automatic db_word_t feature_word(input int x, input int y, input int w, input int h);
		db_word_t word;
		word = '0;
		word.feature.tag = TAG_FEATURE;
		word.feature.x = 4'(x);
		word.feature.y = 4'(y);
		word.feature.w_m1 = 3'(w - 1);
		word.feature.h_m1 = 3'(h - 1);
		return word;
	endfunction

	function automatic db_word_t score_word(input db_tag_t tag, input int code, input int value);
		db_word_t word;
		word = '0;
		word.score.tag = tag;
		word.score.code = 8'(code);
		word.score.value = db_value_t'(value);
		return word;
	endfunction

	task automatic load_cascades();
		rom[0] = score_word(TAG_STAGE_END, 0, 2000); // Always rejects.
		rom[1] = score_word(TAG_CASCADE_END, 0, 0);
		rom[2] = score_word(TAG_STAGE_END, 0, 0);
		rom[3] = score_word(TAG_CASCADE_END, 0, 0);
		rom[4] = feature_word(1, 1, 3, 3);
		rom[5] = score_word(TAG_LEAF, 8'hff, 5);
		rom[6] = score_word(TAG_LEAF, 8'h3c, 3);
		rom[7] = score_word(TAG_LEAF, 8'h0f, -2);
		rom[8] = score_word(TAG_STAGE_END, 0, 1);
		rom[9] = feature_word(0, 0, 2, 2);
		rom[10] = score_word(TAG_LEAF, 8'hff, 4);
		rom[11] = score_word(TAG_LEAF, 8'h3c, 6);
		rom[12] = score_word(TAG_LEAF, 8'h00, 2);
		rom[13] = score_word(TAG_STAGE_END, 0, 2);
		rom[14] = score_word(TAG_CASCADE_END, 0, 0);
		rom[15] = feature_word(2, 1, 2, 3);
		rom[16] = score_word(TAG_LEAF, 8'hf0, 3);
		rom[17] = score_word(TAG_LEAF, 8'h0f, 3);
		rom[18] = score_word(TAG_LEAF, 8'hff, -1);
		rom[19] = score_word(TAG_STAGE_END, 0, -1);
		rom[20] = feature_word(1, 2, 3, 2);
		rom[21] = score_word(TAG_LEAF, 8'h00, -5);
		rom[22] = score_word(TAG_LEAF, 8'h1e, 2);
		rom[23] = score_word(TAG_STAGE_END, 0, -4);
		rom[24] = score_word(TAG_CASCADE_END, 0, 0);
	endtask

	// Raster order until the controller stops asking.
	task automatic send_frame(input int pattern);
		logic stop;
		stop = 1'b0;
		for (int y = 0; y < OH; y++)
		begin
			for (int x = 0; x < OW; x++)
			begin
				if (!stop)
				begin
					@(negedge clk);
					if (o_pixel_request)
					begin
						i_pixel_valid = 1'b1;
						i_ori_x = coord_t'(x);
						i_ori_y = coord_t'(y);
						case (pattern)
							0: i_pixel = 8'd100;
							1: i_pixel = pixel_t'(x*6 + y*3);
							default: i_pixel = pixel_t'($random(seed));
						endcase
					end
					else
					begin
						i_pixel_valid = 1'b0;
						stop = 1'b1;
					end
				end
			end
		end
		if (!stop)
		begin
			@(negedge clk);
			i_pixel_valid = 1'b0;
		end
	endtask

	task automatic wait_done();
		do
		begin
			@(negedge clk);
		end
		while (!o_inspect_done);
	endtask

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Every third request cycle gets a word when gaps are on.
	initial
	begin
		forever
		begin
			@(negedge clk);
			if (o_database_request && (!gaps_active || gap_count == 2))
			begin
				i_db_valid = 1'b1;
				i_db_word = rom[db_ptr];
				db_ptr++;
				gap_count = 0;
			end
			else
			begin
				i_db_valid = 1'b0;
				if (o_database_request)
				begin
					gap_count++;
				end
			end
		end
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired before all tests finished");
		$display("Test failures found");
		$finish;
	end

	initial
	begin
		reset = 1'b1;
		i_pixel_valid = 1'b0;
		i_pixel = '0;
		i_ori_x = '0;
		i_ori_y = '0;
		i_db_valid = 1'b0;
		i_db_word = '0;
		seed = 94;
		db_ptr = 0;
		gap_count = 0;
		gaps_active = 1'b0;
		expected_candidate = -1;
		load_cascades();
		repeat (2) @(negedge clk);
		reset = 1'b0;
		for (int t = 0; t < NUM_TESTS; t++)
		begin
			expected_candidate = test_expected[t];
			gaps_active = test_gaps[t] != 0;
			gap_count = 0;
			db_ptr = cascade_start[test_cascade[t]];
			send_frame(test_pattern[t]);
			wait_done();
			wait (tests_done == t + 1); // Decision compared before the next entry.
		end
		repeat (3) @(negedge clk);
		$display("tests %0d of %0d, errors %0d", tests_done, NUM_TESTS, check_errors);
		if (check_errors == 0 && tests_done == NUM_TESTS)
		begin
			$display("All tests passed!");
		end
		else
		begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* all.f */
source/image_pkg.sv
source/cascade_pkg.sv
source/coordinate_resizer.sv
source/integral_frame_memory.sv
source/lbp_cascade_evaluator.sv
source/i2lbs_detector.sv
dv/i2lbs_properties.sv
dv/i2lbs_checker.sv
dv/i2lbs_tb.sv

/* Makefile */
SIM = verilator
SIM_FLAGS = --binary --timing --assert -Wno-fatal
TOP = i2lbs_tb
FILE_LIST = all.f
OBJ_DIR = obj_dir
BIN = $(OBJ_DIR)/V$(TOP)
LOG = sim.log
SOURCES = $(shell grep -v '^+' $(FILE_LIST))
FAIL_MSG = Test failures found
PASS_MSG = All tests passed!

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILE_LIST) $(SOURCES)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
